// File: tb.f
source/fbPkg.sv
source/dualPortRam.sv
source/commandRegs.sv
source/fragmentPort.sv
source/frameBuffer.sv
source/streamOut.sv
source/fbTop.sv
verification/fbTop_checker.sv
verification/fbTestbench.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal --top-module fbTestbench \
    -Mdir build -o simv -f tb.f \
    && ./build/simv > build/sim.log 2>&1 \
    || { cat build/sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat build/sim.log
grep -q "Checks failed" build/sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0

// File: verification/fbTestbench.sv
// Directed testbench for the tile framebuffer with a pixel reference model, used as simulation top
module fbTestbench;
    timeunit 1ns;
    timeprecision 1ps;

    // Roughly twice the length of all tests at half-rate ready
    localparam int CycleLimit = 4000;

    logic                              clk;
    logic                              reset;
    fbPkg::wbReq_t                     wbReq;
    fbPkg::wbRsp_t                     wbRsp;
    fbPkg::fragWrite_t                 fragWrite;
    logic [fbPkg::IndexWidth-1:0]      readIndex;
    logic [fbPkg::PixelWidth-1:0]      readPixel;
    fbPkg::streamBeat_t                beat;
    logic                              valid;
    logic                              ready;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     startErrors = 0;

    // Reference frame and the scissor state as the host programmed it
    logic [fbPkg::PixelWidth-1:0] model [fbPkg::FrameSize];
    int   scStartX;
    int   scStartY;
    int   scEndX;
    int   scEndY;
    logic scEnable;

    fbTop dut0
    (
        .clk(clk),
        .reset(reset),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .fragWrite(fragWrite),
        .readIndex(readIndex),
        .readPixel(readPixel),
        .beat(beat),
        .valid(valid),
        .ready(ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic expectEqual(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch at %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic finishTest(input string name);
        $display("Test %-22s finished with %0d errors", name, errors - startErrors);
        startErrors = errors;
    endtask

    // Masking and scissor rules with the end edges excluded
    function automatic void modelWrite(input int index, input logic [15:0] color,
                                       input logic [3:0] mask);
        int   x;
        int   y;
        logic inRect;
        x = index % fbPkg::FrameWidth;
        y = index / fbPkg::FrameWidth;
        inRect = (x >= scStartX) && (x < scEndX) && (y >= scStartY) && (y < scEndY);
        if (scEnable && !inRect)
            return;
        for (int c = 0; c < fbPkg::SubPixels; c++)
        begin
            if (mask[c])
                model[index][c*fbPkg::SubPixelWidth +: fbPkg::SubPixelWidth] =
                    color[c*fbPkg::SubPixelWidth +: fbPkg::SubPixelWidth];
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic hostAccess(input logic isWrite, input fbPkg::regAddr_e adr,
                              input logic [31:0] data, output logic [31:0] readData);
        int acks;
        int waited;
        acks = 0;
        waited = 0;
        readData = '0;
        @(negedge clk);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: isWrite, adr: adr, dat: data};
        while (acks == 0 && waited < 8)
        begin
            @(negedge clk);
            waited++;
            if (wbRsp.ack)
            begin
                acks++;
                readData = wbRsp.dat;
            end
        end
        if (acks == 0)
            reportProblem($sformatf("register %s never acknowledged", adr.name()));
        // Hold the request two cycles past the ack cycle to catch a second ack
        repeat (2)
        begin
            @(negedge clk);
            if (wbRsp.ack)
                acks++;
        end
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        @(negedge clk);
        if (wbRsp.ack)
            acks++;
        expectEqual(acks, 1, $sformatf("ack count for %s", adr.name()));
    endtask

    task automatic wbWrite(input fbPkg::regAddr_e adr, input logic [31:0] data);
        logic [31:0] unused;
        hostAccess(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input fbPkg::regAddr_e adr, output logic [31:0] data);
        hostAccess(1'b0, adr, 32'h0, data);
    endtask

    // Control word keeps the scissor enable the model believes in
    task automatic issueCommand(input logic commit, input logic memset);
        wbWrite(fbPkg::RegControl, {29'h0, scEnable, memset, commit});
    endtask

    task automatic waitIdle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        status = 32'h8;
        while (status[3] && polls < 100)
        begin
            wbRead(fbPkg::RegControl, status);
            polls++;
        end
        if (status[3])
            reportProblem("framebuffer stayed busy after the command");
    endtask

    task automatic writeFragment(input int index, input logic [15:0] color,
                                 input logic [3:0] mask);
        @(negedge clk);
        fragWrite = '{en: 1'b1, index: fbPkg::IndexWidth'(index), color: color, mask: mask};
        modelWrite(index, color, mask);
        @(negedge clk);
        fragWrite.en = 1'b0;
    endtask

    // Pixel arrives two cycles after the index
    task automatic readFragment(input int index, output logic [15:0] pixel);
        @(negedge clk);
        readIndex = fbPkg::IndexWidth'(index);
        repeat (2) @(negedge clk);
        pixel = readPixel;
    endtask

    // One read per cycle with each result compared two cycles after its index
    task automatic compareFrame(input string label);
        for (int k = 0; k < fbPkg::FrameSize + 2; k++)
        begin
            @(negedge clk);
            if (k < fbPkg::FrameSize)
                readIndex = fbPkg::IndexWidth'(k);
            if (k >= 2)
                expectEqual(readPixel, model[k-2], $sformatf("%s pixel %0d", label, k - 2));
        end
    endtask

    task automatic collectStream(input string label);
        int          beats;
        int          waited;
        logic [31:0] expected;
        beats = 0;
        waited = 0;
        while (beats < fbPkg::BeatsPerFrame && waited < 1000)
        begin
            @(negedge clk);
            waited++;
            ready = 1'($random(seed));
            if (valid && ready)
            begin
                expected = {model[2*beats+1], model[2*beats]};
                expectEqual(beat.data, expected, $sformatf("%s beat %0d", label, beats));
                expectEqual(beat.last, beats == fbPkg::BeatsPerFrame - 1, "last flag");
                beats++;
            end
        end
        if (beats < fbPkg::BeatsPerFrame)
            reportProblem($sformatf("%s delivered only %0d of 64 beats", label, beats));
        @(negedge clk);
        ready = 1'b0;
        expectEqual(valid, 1'b0, "valid after the last transfer");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic registerReadback();
        logic [31:0] value;
        logic [31:0] readBack;
        for (int r = 0; r < 3; r++)
        begin
            value = {16'h0, 16'($random(seed))};
            wbWrite(fbPkg::regAddr_e'(r), value);
            wbRead(fbPkg::regAddr_e'(r), readBack);
            expectEqual(readBack, value, $sformatf("register %0d readback", r));
        end
    endtask

    task automatic memsetThenCommit();
        logic [15:0] color;
        color = 16'($random(seed));
        wbWrite(fbPkg::RegClearColor, {16'h0, color});
        issueCommand(1'b0, 1'b1);
        for (int k = 0; k < fbPkg::FrameSize; k++)
            model[k] = color;
        waitIdle();
        issueCommand(1'b1, 1'b0);
        collectStream("cleared frame");
        waitIdle();
    endtask

    task automatic maskedFragments();
        int          index;
        logic [15:0] pixel;
        for (int n = 0; n < 16; n++)
        begin
            index = $unsigned($random(seed)) % fbPkg::FrameSize;
            writeFragment(index, 16'($random(seed)), 4'($random(seed)));
            readFragment(index, pixel);
            expectEqual(pixel, model[index], $sformatf("pixel %0d after write", index));
            // Other lane of the same word
            readFragment(index ^ 1, pixel);
            expectEqual(pixel, model[index ^ 1], $sformatf("neighbor %0d", index ^ 1));
        end
        compareFrame("masked");
    endtask

    task automatic scissorClipping();
        scStartX = 3;
        scStartY = 2;
        scEndX = 11;
        scEndY = 6;
        scEnable = 1'b1;
        wbWrite(fbPkg::RegScissorStart, {16'h0, 8'(scStartY), 8'(scStartX)});
        wbWrite(fbPkg::RegScissorEnd, {16'h0, 8'(scEndY), 8'(scEndX)});
        issueCommand(1'b0, 1'b0);
        // Start corner lands while the end edges are clipped
        writeFragment(scStartY * fbPkg::FrameWidth + scStartX, 16'h5a5a, 4'hf);
        writeFragment(scStartY * fbPkg::FrameWidth + scEndX, 16'h1234, 4'hf);
        writeFragment(scEndY * fbPkg::FrameWidth + scStartX, 16'h4321, 4'hf);
        for (int n = 0; n < 24; n++)
            writeFragment($unsigned($random(seed)) % fbPkg::FrameSize, 16'($random(seed)), 4'hf);
        compareFrame("scissor on");
        scEnable = 1'b0;
        issueCommand(1'b0, 1'b0);
        for (int n = 0; n < 8; n++)
            writeFragment($unsigned($random(seed)) % fbPkg::FrameSize, 16'($random(seed)), 4'hf);
        compareFrame("scissor off");
    endtask

    task automatic commitWithMemset();
        logic [15:0] color;
        color = 16'($random(seed));
        wbWrite(fbPkg::RegClearColor, {16'h0, color});
        issueCommand(1'b1, 1'b1);
        collectStream("frame before clear");
        for (int k = 0; k < fbPkg::FrameSize; k++)
            model[k] = color;
        waitIdle();
        compareFrame("after clear");
    endtask

    task automatic busyControl();
        logic [31:0] status;
        int          strayCycles;
        issueCommand(1'b1, 1'b0);
        wbRead(fbPkg::RegControl, status);
        expectEqual(status[3], 1'b1, "busy flag during commit");
        // Refused while the commit is still running
        issueCommand(1'b1, 1'b1);
        collectStream("commit under busy");
        waitIdle();
        strayCycles = 0;
        repeat (40)
        begin
            @(negedge clk);
            ready = 1'b1;
            if (valid)
                strayCycles++;
        end
        ready = 1'b0;
        if (strayCycles != 0)
            reportProblem("a control write made while busy started a second stream");
    endtask

    initial
    begin
        seed = 57218;
        reset = 1'b1;
        wbReq = '0;
        fragWrite = '0;
        readIndex = '0;
        ready = 1'b0;
        scEnable = 1'b0;
        scStartX = 0;
        scStartY = 0;
        scEndX = 0;
        scEndY = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        registerReadback();
        finishTest("register readback");
        memsetThenCommit();
        finishTest("memset then commit");
        maskedFragments();
        finishTest("masked fragments");
        scissorClipping();
        finishTest("scissor");
        commitWithMemset();
        finishTest("commit with memset");
        busyControl();
        finishTest("busy control");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: verification/fbTop_checker.sv
// Stream protocol assertions for the framebuffer output port, bound into the top level
module fbTop_checker
(
    input logic               clk,
    input logic               reset,
    input logic               valid,
    input logic               ready,
    input fbPkg::streamBeat_t beat
);
    timeunit 1ns;
    timeprecision 1ps;

    // Output stage leaves reset empty
    validAfterReset: assert property (@(posedge clk) reset |=> !valid)
        else $error("valid high in the first cycle after reset");

    // A stalled beat keeps data and last until it is taken
    beatHeld: assert property (@(posedge clk) disable iff (reset)
        (valid && !ready) |=> (valid && $stable(beat)))
        else $error("beat changed or dropped while ready was low");

    lastNeedsValid: assert property (@(posedge clk) disable iff (reset)
        beat.last |-> valid)
        else $error("last high without valid");

endmodule

bind fbTop fbTop_checker streamChecks
(
    .clk(clk),
    .reset(reset),
    .valid(valid),
    .ready(ready),
    .beat(beat)
);

// File: source/fbTop.sv
// Top level of the tile framebuffer joining host registers, fragment path, RAM engine and stream
module fbTop
(
    input  logic                            clk,
    input  logic                            reset,
    input  fbPkg::wbReq_t                   wbReq,
    output fbPkg::wbRsp_t                   wbRsp,
    input  fbPkg::fragWrite_t               fragWrite,
    input  logic [fbPkg::IndexWidth-1:0]    readIndex,
    output logic [fbPkg::PixelWidth-1:0]    readPixel,
    output fbPkg::streamBeat_t              beat,
    output logic                            valid,
    input  logic                            ready
);

    logic                              busy;
    logic                              start;
    fbPkg::fbCommand_t                 command;
    fbPkg::scissor_t                   scissor;
    fbPkg::ramWrite_t                  fragRamWrite;
    logic [fbPkg::WordAddrWidth-1:0]   fragReadAddr;
    logic [fbPkg::StreamWidth-1:0]     ramWord;
    logic                              beatRequest;
    logic                              beatAccepted;

    commandRegs hostRegs
    (
        .clk(clk),
        .reset(reset),
        .wbReq(wbReq),
        .wbRsp(wbRsp),
        .busy(busy),
        .start(start),
        .command(command),
        .scissor(scissor)
    );

    fragmentPort fragPath
    (
        .clk(clk),
        .reset(reset),
        .fragWrite(fragWrite),
        .readIndex(readIndex),
        .scissor(scissor),
        .ramWordIn(ramWord),
        .ramWrite(fragRamWrite),
        .ramReadAddr(fragReadAddr),
        .readPixel(readPixel)
    );

    frameBuffer frameStore
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .command(command),
        .busy(busy),
        .fragRamWrite(fragRamWrite),
        .fragReadAddr(fragReadAddr),
        .ramWordOut(ramWord),
        .beatRequest(beatRequest),
        .ready(ready),
        .beatAccepted(beatAccepted)
    );

    streamOut streamStage
    (
        .clk(clk),
        .reset(reset),
        .beatRequest(beatRequest),
        .ramWord(ramWord),
        .ready(ready),
        .beatAccepted(beatAccepted),
        .beat(beat),
        .valid(valid)
    );

endmodule

// File: source/streamOut.sv
// Output register stage of the commit stream, holding each beat under back-pressure
module streamOut
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            beatRequest,
    input  logic [fbPkg::StreamWidth-1:0]   ramWord,
    input  logic                            ready,
    output logic                            beatAccepted,
    output fbPkg::streamBeat_t              beat,
    output logic                            valid
);

    logic                            load;
    logic                            beatLast;
    logic [fbPkg::StreamWidth-1:0]   beatData;
    logic [fbPkg::WordAddrWidth-1:0] beatCount;

    assign beatAccepted = valid && ready;
    // Take a new word when empty or when the held beat leaves
    assign load = beatRequest && (!valid || ready);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 1'b0;
            beatLast <= 1'b0;
            beatCount <= '0;
        end
        else if (load)
        begin
            valid <= 1'b1;
            beatLast <= (beatCount == fbPkg::WordAddrWidth'(fbPkg::BeatsPerFrame - 1));
            beatCount <= beatCount + 1'b1;
        end
        else if (beatAccepted)
        begin
            valid <= 1'b0;
            beatLast <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            beatData <= ramWord;
    end

    assign beat = '{data: beatData, last: beatLast};

endmodule

// File: source/frameBuffer.sv
// Command engine for memset and commit, arbitrating the frame RAM against the fragment path
module frameBuffer
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  fbPkg::fbCommand_t                 command,
    output logic                              busy,
    input  fbPkg::ramWrite_t                  fragRamWrite,
    input  logic [fbPkg::WordAddrWidth-1:0]   fragReadAddr,
    output logic [fbPkg::StreamWidth-1:0]     ramWordOut,
    output logic                              beatRequest,
    input  logic                              ready,
    input  logic                              beatAccepted
);

    fbPkg::cmdState_e                    state;
    logic [fbPkg::WordAddrWidth:0]       counter;
    logic [fbPkg::WordAddrWidth-1:0]     wordAddr;
    logic                                allLoaded;
    logic                                advance;
    logic                                memsetPending;
    logic [fbPkg::PixelWidth-1:0]        clearColor;
    fbPkg::ramWrite_t                    cmdWrite;
    fbPkg::ramWrite_t                    ramWrite;
    logic [fbPkg::WordAddrWidth-1:0]     cmdReadAddr;
    logic [fbPkg::WordAddrWidth-1:0]     ramReadAddr;

    assign wordAddr = counter[fbPkg::WordAddrWidth-1:0];
    // Top bit set once all 64 words went to the stream stage
    assign allLoaded = counter[fbPkg::WordAddrWidth];

    assign busy = (state != fbPkg::Idle);

    ////////////////////////////////////////////////////////////////////////////
    // Commit read side
    ////////////////////////////////////////////////////////////////////////////

    // CommitInit loads word 0 into an empty stage, later loads ride on ready
    assign beatRequest = (state == fbPkg::CommitInit)
        || ((state == fbPkg::Commit) && !allLoaded);
    assign advance = (state == fbPkg::Commit) && ready && !allLoaded;

    always_comb
    begin
        if (state == fbPkg::CommitInit)
            cmdReadAddr = fbPkg::WordAddrWidth'(1);
        else if (advance)
            cmdReadAddr = wordAddr + 1'b1;
        else
            cmdReadAddr = wordAddr;
    end

    // Word 0 is fetched in the start cycle so it is ready in CommitInit
    always_comb
    begin
        if (busy)
            ramReadAddr = cmdReadAddr;
        else if (start && command.commit)
            ramReadAddr = '0;
        else
            ramReadAddr = fragReadAddr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memset write side
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        cmdWrite.en = (state == fbPkg::Memset);
        cmdWrite.addr = wordAddr;
        cmdWrite.data = {fbPkg::PixelsPerBeat{clearColor}};
        cmdWrite.strobe = '1;
    end

    assign ramWrite = busy ? cmdWrite : fragRamWrite;

    always_ff @(posedge clk)
    begin
        if (!busy && start)
            clearColor <= command.clearColor;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= fbPkg::Idle;
            counter <= '0;
            memsetPending <= 1'b0;
        end
        else
        begin
            case (state)
                fbPkg::Idle:
                begin
                    counter <= '0;
                    if (start)
                    begin
                        memsetPending <= command.memset;
                        // Commit goes first when both are requested
                        state <= command.commit ? fbPkg::CommitInit : fbPkg::Memset;
                    end
                end
                fbPkg::CommitInit:
                begin
                    counter <= 1;
                    state <= fbPkg::Commit;
                end
                fbPkg::Commit:
                begin
                    if (advance)
                        counter <= counter + 1'b1;
                    if (allLoaded && beatAccepted)
                    begin
                        counter <= '0;
                        state <= memsetPending ? fbPkg::Memset : fbPkg::Idle;
                    end
                end
                fbPkg::Memset:
                begin
                    counter <= counter + 1'b1;
                    if (wordAddr == fbPkg::WordAddrWidth'(fbPkg::BeatsPerFrame - 1))
                        state <= fbPkg::Idle;
                end
            endcase
        end
    end

    dualPortRam frameRam
    (
        .clk(clk),
        .reset(reset),
        .write(ramWrite),
        .readAddr(ramReadAddr),
        .readData(ramWordOut)
    );

endmodule

// File: source/fragmentPort.sv
// Pixel pipeline access path: scissor test, write strobes and read lane selection for the RAM
module fragmentPort
(
    input  logic                              clk,
    input  logic                              reset,
    input  fbPkg::fragWrite_t                 fragWrite,
    input  logic [fbPkg::IndexWidth-1:0]      readIndex,
    input  fbPkg::scissor_t                   scissor,
    input  logic [fbPkg::StreamWidth-1:0]     ramWordIn,
    output fbPkg::ramWrite_t                  ramWrite,
    output logic [fbPkg::WordAddrWidth-1:0]   ramReadAddr,
    output logic [fbPkg::PixelWidth-1:0]      readPixel
);

    logic [fbPkg::PosWidth-1:0] posX;
    logic [fbPkg::PosWidth-1:0] posY;
    logic                       scissorPass;
    logic                       writeLane;
    logic                       readLane;

    // Row-major index, 16 pixels per row
    assign posX = fbPkg::PosWidth'(fragWrite.index % fbPkg::FrameWidth);
    assign posY = fbPkg::PosWidth'(fragWrite.index / fbPkg::FrameWidth);

    // End edges are outside the rectangle
    assign scissorPass = !scissor.enable
        || ((posX >= scissor.startX) && (posX < scissor.endX)
            && (posY >= scissor.startY) && (posY < scissor.endY));

    // Two pixels per word, the low index bit picks the lane
    assign writeLane = fragWrite.index[0];

    always_comb
    begin
        ramWrite.en = fragWrite.en && scissorPass;
        ramWrite.addr = fragWrite.index[fbPkg::IndexWidth-1:1];
        ramWrite.data = {fbPkg::PixelsPerBeat{fragWrite.color}};
        ramWrite.strobe = '0;
        for (int l = 0; l < fbPkg::PixelsPerBeat; l++)
        begin
            if (writeLane == l)
                ramWrite.strobe[l*fbPkg::SubPixels +: fbPkg::SubPixels] = fragWrite.mask;
        end
    end

    assign ramReadAddr = readIndex[fbPkg::IndexWidth-1:1];

    // Lane follows the RAM latency
    always_ff @(posedge clk)
    begin
        if (reset)
            readLane <= 1'b0;
        else
            readLane <= readIndex[0];
    end

    always_ff @(posedge clk)
    begin
        readPixel <= ramWordIn[readLane*fbPkg::PixelWidth +: fbPkg::PixelWidth];
    end

endmodule

// File: source/commandRegs.sv
// Wishbone classic register block that holds clear color, scissor and issues framebuffer commands
module commandRegs
(
    input  logic              clk,
    input  logic              reset,
    input  fbPkg::wbReq_t     wbReq,
    output fbPkg::wbRsp_t     wbRsp,
    input  logic              busy,
    output logic              start,
    output fbPkg::fbCommand_t command,
    output fbPkg::scissor_t   scissor
);

    logic                         request;
    logic                         ack;
    logic                         served;
    logic                         controlWrite;
    logic [fbPkg::PixelWidth-1:0] clearColor;

    assign request = wbReq.cyc && wbReq.stb;

    // Single ack per strobe, rearmed once the master drops stb
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack <= 1'b0;
            served <= 1'b0;
        end
        else
        begin
            ack <= request && !served && !ack;
            if (ack)
                served <= 1'b1;
            else if (!wbReq.stb)
                served <= 1'b0;
        end
    end

    assign controlWrite = ack && wbReq.we && (wbReq.adr == fbPkg::RegControl);

    // Register writes take the data of the ack cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clearColor <= '0;
            scissor <= '0;
        end
        else if (ack && wbReq.we)
        begin
            unique case (wbReq.adr)
                fbPkg::RegClearColor:   clearColor <= wbReq.dat[fbPkg::PixelWidth-1:0];
                fbPkg::RegScissorStart:
                begin
                    scissor.startX <= wbReq.dat[7:0];
                    scissor.startY <= wbReq.dat[15:8];
                end
                fbPkg::RegScissorEnd:
                begin
                    scissor.endX <= wbReq.dat[7:0];
                    scissor.endY <= wbReq.dat[15:8];
                end
                fbPkg::RegControl:      scissor.enable <= wbReq.dat[2];
            endcase
        end
    end

    // A busy framebuffer or an empty command only updates the enable
    assign start = controlWrite && !busy && (wbReq.dat[0] || wbReq.dat[1]);
    assign command.commit = wbReq.dat[0];
    assign command.memset = wbReq.dat[1];
    assign command.clearColor = clearColor;

    always_comb
    begin
        wbRsp.ack = ack;
        unique case (wbReq.adr)
            fbPkg::RegClearColor:   wbRsp.dat = 32'(clearColor);
            fbPkg::RegScissorStart: wbRsp.dat = {16'h0, scissor.startY, scissor.startX};
            fbPkg::RegScissorEnd:   wbRsp.dat = {16'h0, scissor.endY, scissor.endX};
            fbPkg::RegControl:      wbRsp.dat = {28'h0, busy, scissor.enable, 2'b00};
        endcase
    end

endmodule

// File: source/dualPortRam.sv
// Frame storage RAM with one write port, one registered read port and channel write strobes
module dualPortRam
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  fbPkg::ramWrite_t                       write,
    input  logic [fbPkg::WordAddrWidth-1:0]        readAddr,
    output logic [fbPkg::StreamWidth-1:0]          readData
);

    logic [fbPkg::StreamWidth-1:0] mem [fbPkg::BeatsPerFrame];

    // Each strobe bit covers one 4-bit channel of the word
    always_ff @(posedge clk)
    begin
        if (write.en && !reset)
        begin
            for (int s = 0; s < fbPkg::StrobeWidth; s++)
            begin
                if (write.strobe[s])
                begin
                    mem[write.addr][s*fbPkg::SubPixelWidth +: fbPkg::SubPixelWidth] <=
                        write.data[s*fbPkg::SubPixelWidth +: fbPkg::SubPixelWidth];
                end
            end
        end
    end

    // One cycle of read latency
    always_ff @(posedge clk)
    begin
        readData <= mem[readAddr];
    end

endmodule

// File: source/fbPkg.sv
// Frame dimensions, bus structs and state enums shared by every block of the tile framebuffer
package fbPkg;

    localparam int FrameWidth = 16;
    localparam int FrameHeight = 8;
    localparam int FrameSize = FrameWidth * FrameHeight;
    localparam int SubPixelWidth = 4;
    localparam int SubPixels = 4;
    localparam int PixelWidth = SubPixelWidth * SubPixels;
    localparam int StreamWidth = 32;
    localparam int PixelsPerBeat = StreamWidth / PixelWidth;
    localparam int BeatsPerFrame = FrameSize / PixelsPerBeat;
    localparam int IndexWidth = $clog2(FrameSize);
    localparam int WordAddrWidth = $clog2(BeatsPerFrame);
    localparam int PosWidth = 8;
    localparam int StrobeWidth = StreamWidth / SubPixelWidth;

    typedef enum logic [1:0] {
        RegClearColor   = 2'd0,
        RegScissorStart = 2'd1,
        RegScissorEnd   = 2'd2,
        RegControl      = 2'd3
    } regAddr_e;

    typedef enum logic [1:0] {
        Idle       = 2'd0,
        CommitInit = 2'd1,
        Commit     = 2'd2,
        Memset     = 2'd3
    } cmdState_e;

    ////////////////////////////////////////////////////////////////////////////
    // Host bus
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        regAddr_e    adr;
        logic [31:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Internal and pixel side
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                enable;
        logic [PosWidth-1:0] startX;
        logic [PosWidth-1:0] startY;
        logic [PosWidth-1:0] endX;
        logic [PosWidth-1:0] endY;
    } scissor_t;

    // Only meaningful in the cycle where start is high
    typedef struct packed {
        logic                  commit;
        logic                  memset;
        logic [PixelWidth-1:0] clearColor;
    } fbCommand_t;

    typedef struct packed {
        logic                  en;
        logic [IndexWidth-1:0] index;
        logic [PixelWidth-1:0] color;
        logic [SubPixels-1:0]  mask;
    } fragWrite_t;

    typedef struct packed {
        logic                     en;
        logic [WordAddrWidth-1:0] addr;
        logic [StreamWidth-1:0]   data;
        logic [StrobeWidth-1:0]   strobe;
    } ramWrite_t;

    typedef struct packed {
        logic [StreamWidth-1:0] data;
        logic                   last;
    } streamBeat_t;

endpackage
